// File: verilog/ascon_pkg.sv
// ascon permutation package

package ascon_pkg;

    localparam int WORD_W    = 64;              // one state word
    localparam int NUM_WORDS = 5;               // x0 .. x4
    localparam int STATE_W   = NUM_WORDS * WORD_W;

    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [STATE_W-1:0] state_t;       // x0 sits in the low 64 bits

    localparam int ROUNDS_FULL  = 12;           // pa schedule
    localparam int ROUNDS_SHORT = 6;            // pb schedule, tail of pa

    typedef logic [3:0] round_idx_t;            // 0 .. 11

    // round constant is RC_BASE - i*RC_STEP in the low byte
    localparam logic [7:0] RC_BASE = 8'hF0;
    localparam logic [7:0] RC_STEP = 8'h0F;

    // diffusion rotation pairs, entry i belongs to word i
    localparam int ROT_A [NUM_WORDS] = '{19, 61, 1, 10, 7};
    localparam int ROT_B [NUM_WORDS] = '{28, 39, 6, 17, 41};

    // constant for a given round index
    function automatic word_t round_const(input round_idx_t idx);
        logic [7:0] rc;
        rc = RC_BASE - (8'(idx) * RC_STEP);     // never underflows for idx <= 11
        return {{(WORD_W-8){1'b0}}, rc};
    endfunction

endpackage

// File: verilog/ascon_round_if.sv
// round control interface
`timescale 1ns/100ps

interface ascon_round_if import ascon_pkg::*; ();

    logic       load;       // start accepted this cycle
    logic       step;       // a round is applied this cycle
    round_idx_t round_idx;  // index of the round being applied
    logic       finish;     // last round of the run

    // controller side
    modport ctrl (
        output load,
        output step,
        output round_idx,
        output finish
    );

    // datapath side
    modport dp (
        input load,
        input step,
        input round_idx,
        input finish
    );

endinterface

// File: verilog/ascon_round_ctrl.sv
// permutation round controller
`timescale 1ns/100ps

module ascon_round_ctrl import ascon_pkg::*; (
    input  logic clk,
    input  logic i_arst_n,
    input  logic i_start,          // single cycle start strobe
    input  logic i_short,          // 1 = 6 rounds, 0 = 12 rounds
    output logic o_busy,
    output logic o_done,           // single cycle done strobe
    ascon_round_if.ctrl rif
);

    localparam round_idx_t LAST_IDX  = round_idx_t'(ROUNDS_FULL - 1);
    localparam round_idx_t SHORT_IDX = round_idx_t'(ROUNDS_FULL - ROUNDS_SHORT);

    logic       busy_q;             // a run is in progress
    logic       done_q;             // registered done strobe
    round_idx_t idx_q;              // current round index
    round_idx_t first_idx;          // starting index of the chosen schedule
    logic       accept;             // start gated against busy
    logic       last_round;

    // short schedule is the last six rounds of the long one
    assign first_idx  = i_short ? SHORT_IDX : '0;
    assign accept     = i_start & ~busy_q;              // starts while busy are dropped
    assign last_round = busy_q && (idx_q == LAST_IDX);

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            idx_q  <= '0;
        end else begin
            done_q <= last_round;                       // done lands with busy falling
            if (accept) begin
                busy_q <= 1'b1;
                idx_q  <= first_idx;
            end else if (last_round) begin
                busy_q <= 1'b0;                         // index parks at 11
            end else if (busy_q) begin
                idx_q <= idx_q + 1'b1;
            end
        end
    end

    // datapath controls
    assign rif.load      = accept;
    assign rif.step      = busy_q;  // one round per busy cycle
    assign rif.round_idx = idx_q;
    assign rif.finish    = last_round;

    assign o_busy = busy_q;
    assign o_done = done_q;

endmodule

// File: verilog/ascon_sbox_layer.sv
// bit sliced substitution layer
`timescale 1ns/100ps

module ascon_sbox_layer import ascon_pkg::*; (
    input  state_t i_state,
    output state_t o_state
);

    always_comb begin
        logic [NUM_WORDS-1:0] a;    // column after first affine step
        logic [NUM_WORDS-1:0] n;    // column after chi
        logic [NUM_WORDS-1:0] c;    // column after second affine step
        o_state = '0;
        for (int b = 0; b < WORD_W; b++) begin
            // gather bit b of every word, a[w] is word w
            for (int w = 0; w < NUM_WORDS; w++) begin
                a[w] = i_state[w*WORD_W + b];
            end

            // first affine step
            a[0] = a[0] ^ a[4];
            a[4] = a[4] ^ a[3];
            a[2] = a[2] ^ a[1];

            // nonlinear step, all terms from the pre-chi column
            for (int w = 0; w < NUM_WORDS; w++) begin
                n[w] = a[w] ^ (~a[(w+1) % NUM_WORDS] & a[(w+2) % NUM_WORDS]);
            end

            // second affine step
            c[1] = n[1] ^ n[0];
            c[0] = n[0] ^ n[4];
            c[3] = n[3] ^ n[2];
            c[2] = ~n[2];               // x2 inversion
            c[4] = n[4];

            // scatter column back into the words
            for (int w = 0; w < NUM_WORDS; w++) begin
                o_state[w*WORD_W + b] = c[w];
            end
        end
    end

endmodule

// File: verilog/ascon_linear_layer.sv
// linear diffusion layer
`timescale 1ns/100ps

module ascon_linear_layer import ascon_pkg::*; (
    input  state_t i_state,
    output state_t o_state
);

    for (genvar i = 0; i < NUM_WORDS; i++) begin : g_word
        localparam int RA = ROT_A[i];   // first rotation of word i
        localparam int RB = ROT_B[i];   // second rotation of word i

        word_t w;
        word_t rot_a;
        word_t rot_b;

        assign w = i_state[i*WORD_W +: WORD_W];

        // right rotations as fixed rewiring
        assign rot_a = {w[RA-1:0], w[WORD_W-1:RA]};
        assign rot_b = {w[RB-1:0], w[WORD_W-1:RB]};

        assign o_state[i*WORD_W +: WORD_W] = w ^ rot_a ^ rot_b;
    end

endmodule

// File: verilog/ascon_perm_top.sv
// ascon permutation engine
`timescale 1ns/100ps

module ascon_perm_top import ascon_pkg::*; (
    input  logic   clk,
    input  logic   i_arst_n,
    input  logic   i_start,     // start strobe, ignored while busy
    input  logic   i_short,     // 6 rounds when high
    input  state_t i_state,     // state sampled on an accepted start
    output state_t o_state,     // live state, holds result after done
    output logic   o_busy,
    output logic   o_done       // one cycle strobe on the last round edge
);

    ascon_round_if rif ();      // controller to datapath

    state_t state_q;            // x4..x0 state register
    state_t rc_state;           // state with round constant in x2
    state_t sbox_state;         // after substitution
    state_t lin_state;          // after diffusion, next round value
    word_t  rc_word;

    // round sequencing
    ascon_round_ctrl u_ctrl (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_start  (i_start),
        .i_short  (i_short),
        .o_busy   (o_busy),
        .o_done   (o_done),
        .rif      (rif)
    );

    // constant addition, only x2 is touched
    assign rc_word = round_const(rif.round_idx);

    always_comb begin
        rc_state = state_q;
        rc_state[2*WORD_W +: WORD_W] = state_q[2*WORD_W +: WORD_W] ^ rc_word;
    end

    // substitution layer over all 64 columns
    ascon_sbox_layer u_sbox (
        .i_state (rc_state),
        .o_state (sbox_state)
    );

    // diffusion per word
    ascon_linear_layer u_linear (
        .i_state (sbox_state),
        .o_state (lin_state)
    );

    // one full round per step cycle
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= '0;
        end else if (rif.load) begin
            state_q <= i_state;             // load and step never overlap
        end else if (rif.step) begin
            state_q <= lin_state;
        end
    end

    assign o_state = state_q;   // result stays until the next load

endmodule

// File: dv/ascon_perm_sva.sv
// round controller assertions
`timescale 1ns/100ps

module ascon_perm_sva import ascon_pkg::*; (
    input logic       clk,
    input logic       i_arst_n,
    input logic       i_busy,       // controller busy flag
    input logic       i_done,       // done strobe
    input logic       i_load,       // start accepted
    input logic       i_finish,     // last round this cycle
    input round_idx_t i_round_idx
);

    // done only shows up once busy has fallen
    a_done_not_busy : assert property (@(posedge clk) disable iff (!i_arst_n)
        !(i_done && i_busy))
        else $error("done and busy high in the same cycle");

    a_done_single : assert property (@(posedge clk) disable iff (!i_arst_n)
        i_done |=> !i_done)   // strobe lasts one cycle
        else $error("done strobe longer than one cycle");

    // an accepted start opens a run on the next edge
    a_load_run : assert property (@(posedge clk) disable iff (!i_arst_n)
        i_load |=> (i_busy && !i_done))
        else $error("accepted start did not open a run");

    // the last round closes the run with a done strobe
    a_finish_done : assert property (@(posedge clk) disable iff (!i_arst_n)
        i_finish |=> (i_done && !i_busy))
        else $error("last round did not end the run with done");

    a_idx_step : assert property (@(posedge clk) disable iff (!i_arst_n)
        (i_busy && !i_finish) |=> (i_round_idx == $past(i_round_idx) + 1'b1))
        else $error("round index did not advance by one");   // one round per cycle

endmodule

// hooked to the controller's own nets behind rif
bind ascon_round_ctrl ascon_perm_sva u_sva (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_busy      (o_busy),
    .i_done      (o_done),
    .i_load      (accept),
    .i_finish    (last_round),
    .i_round_idx (idx_q)
);

// File: dv/ascon_perm_tb.sv
// ascon permutation testbench
`timescale 1ns/100ps

module ascon_perm_tb import ascon_pkg::*; ();

    localparam int CLK_NS     = 20;
    localparam int RST_CYCLES = 8;
    localparam int NUM_RAND   = 20;                 // random states per schedule
    localparam int NUM_TESTS  = 2 * NUM_RAND + 2;   // plus two double start runs
    localparam int WATCHDOG_NS = (NUM_TESTS * 20 + RST_CYCLES + 100) * CLK_NS;

    logic   clk;
    logic   i_arst_n;
    logic   i_start;
    logic   i_short;
    state_t i_state;
    state_t o_state;
    logic   o_busy;
    logic   o_done;

    integer seed;
    int     value_errors;
    int     proto_errors;
    int     starts;             // accepted runs
    int     dones;              // done strobes seen
    state_t exp_q [$];          // expected results in start order

    ascon_perm_top dut (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_start  (i_start),
        .i_short  (i_short),
        .i_state  (i_state),
        .o_state  (o_state),
        .o_busy   (o_busy),
        .o_done   (o_done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    function automatic logic [63:0] rotate_right(input logic [63:0] v, input int n);
        return (v >> n) | (v << (64 - n));
    endfunction

    // word level model of the permutation, last `rounds` rounds of pa
    function automatic state_t ascon_ref(input state_t s, input int rounds);
        logic [63:0] x [5];
        logic [63:0] t [5];
        state_t      r;
        for (int i = 0; i < 5; i++) x[i] = s[i*64 +: 64];
        for (int rnd = 12 - rounds; rnd < 12; rnd++) begin
            x[2] ^= {56'h0, 4'(15 - rnd), 4'(rnd)};     // f0, e1, d2 ...
            x[0] ^= x[4];
            x[4] ^= x[3];
            x[2] ^= x[1];
            for (int i = 0; i < 5; i++) t[i] = ~x[i] & x[(i + 1) % 5];
            for (int i = 0; i < 5; i++) x[i] ^= t[(i + 1) % 5];
            x[1] ^= x[0];
            x[0] ^= x[4];
            x[3] ^= x[2];
            x[2] = ~x[2];
            x[0] ^= rotate_right(x[0], 19) ^ rotate_right(x[0], 28);
            x[1] ^= rotate_right(x[1], 61) ^ rotate_right(x[1], 39);
            x[2] ^= rotate_right(x[2], 1) ^ rotate_right(x[2], 6);
            x[3] ^= rotate_right(x[3], 10) ^ rotate_right(x[3], 17);
            x[4] ^= rotate_right(x[4], 7) ^ rotate_right(x[4], 41);
        end
        for (int i = 0; i < 5; i++) r[i*64 +: 64] = x[i];
        return r;
    endfunction

    task automatic random_state(output state_t s);
        for (int i = 0; i < STATE_W / 32; i++) begin
            s[i*32 +: 32] = $random(seed);
        end
    endtask

    // one run from start strobe to done, then idle with the result held
    task automatic run_perm(input state_t s, input logic short_sel,
                            input logic second_start, input int hold_cycles);
        int     n;
        int     cycles;
        state_t other;
        state_t expected;
        n = short_sel ? ROUNDS_SHORT : ROUNDS_FULL;
        random_state(other);
        expected = ascon_ref(s, n);
        exp_q.push_back(expected);
        starts++;
        i_state = s;
        i_short = short_sel;
        i_start = 1'b1;
        @(negedge clk);
        i_start = 1'b0;
        i_state = other;                // must not leak into the run
        cycles  = 0;
        while (!o_done && cycles <= n) begin
            if (!o_busy) begin
                $display("busy low %0d cycles after the start was taken", cycles);
                proto_errors++;
            end
            i_start = second_start && (cycles == 2);    // stray start mid run
            @(negedge clk);
            cycles++;
        end
        i_start = 1'b0;
        if (!o_done) begin
            $display("done missing %0d cycles after start", cycles);
            proto_errors++;
        end else if (cycles != n) begin
            $display("done came %0d cycles after start instead of %0d", cycles, n);
            proto_errors++;
        end
        // result must stay on o_state while idle
        repeat (hold_cycles) begin
            @(negedge clk);
            if (o_state !== expected) begin
                $display("Fail o_state expected %h actual %h", expected, o_state);
                value_errors++;
            end
            if (o_busy || o_done) begin
                $display("engine busy or done while idle after a run");
                proto_errors++;
            end
        end
    endtask

    // compare process, checks every done strobe against the model
    initial begin
        state_t expected;
        forever begin
            @(negedge clk);
            if (o_done) begin
                dones++;
                if (exp_q.size() == 0) begin
                    $display("unexpected done with no run pending");
                    proto_errors++;
                end else begin
                    expected = exp_q.pop_front();
                    if (o_state !== expected) begin
                        $display("Fail o_state expected %h actual %h", expected, o_state);
                        value_errors++;
                    end
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        state_t s;
        seed         = 40068;
        value_errors = 0;
        proto_errors = 0;
        starts       = 0;
        dones        = 0;
        i_arst_n     = 1'b0;
        i_start      = 1'b0;
        i_short      = 1'b0;
        i_state      = '0;
        repeat (RST_CYCLES) @(negedge clk);
        i_arst_n = 1'b1;
        @(negedge clk);
        if (o_busy || o_done) begin
            $display("busy or done high after reset");
            proto_errors++;
        end
        if (o_state !== '0) begin
            $display("Fail o_state expected %h actual %h", state_t'(0), o_state);
            value_errors++;
        end
        for (int k = 0; k < NUM_RAND; k++) begin     // 12 round schedule
            random_state(s);
            run_perm(s, 1'b0, 1'b0, 2);
        end
        for (int k = 0; k < NUM_RAND; k++) begin     // 6 round schedule
            random_state(s);
            run_perm(s, 1'b1, 1'b0, 2);
        end
        random_state(s);
        run_perm(s, 1'b0, 1'b1, 8);                 // second start ignored, long hold
        random_state(s);
        run_perm(s, 1'b1, 1'b1, 8);
        repeat (4) @(negedge clk);
        if (dones != starts) begin
            $display("saw %0d done strobes for %0d runs", dones, starts);
            proto_errors++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d runs never reported done", exp_q.size());
            proto_errors++;
        end
        $display("runs %0d, done strobes %0d, value errors %0d, protocol errors %0d",
                 starts, dones, value_errors, proto_errors);
        if (value_errors + proto_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: list.f
verilog/ascon_pkg.sv
verilog/ascon_round_if.sv
verilog/ascon_round_ctrl.sv
verilog/ascon_sbox_layer.sv
verilog/ascon_linear_layer.sv
verilog/ascon_perm_top.sv
dv/ascon_perm_sva.sv
dv/ascon_perm_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the ASCON permutation testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module ascon_perm_tb -f list.f -o ascon_perm_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/ascon_perm_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0
